// ==== source/host_bridge_pkg.sv ====
package host_bridge_pkg;

  // payload words
  typedef logic [31:0] host_word_t;
  typedef logic [15:0] htif_word_t;

  typedef logic [6:0] axil_addr_t;
  typedef logic [4:0] reg_idx_t;  // word index, addr bits 6:2

  // everything the bus master drives
  typedef struct packed {
    logic       aw_valid;
    axil_addr_t aw_addr;
    logic       w_valid;
    logic [31:0] w_data;
    logic [3:0] w_strb;
    logic       b_ready;
    logic       ar_valid;
    axil_addr_t ar_addr;
    logic       r_ready;
  } axil_req_t;

  // everything the slave drives back
  typedef struct packed {
    logic        aw_ready;
    logic        w_ready;
    logic        b_valid;
    logic [1:0]  b_resp;
    logic        ar_ready;
    logic        r_valid;
    logic [31:0] r_data;
    logic [1:0]  r_resp;
  } axil_rsp_t;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // readable registers
  localparam reg_idx_t REG_HOST_OUT_COUNT = 5'd0;
  localparam reg_idx_t REG_HOST_OUT_DATA  = 5'd1;
  localparam reg_idx_t REG_HTIF_OUT_COUNT = 5'd2;
  localparam reg_idx_t REG_HTIF_OUT_DATA  = 5'd3;
  localparam reg_idx_t REG_HOST_IN_COUNT  = 5'd4;
  localparam reg_idx_t REG_HTIF_IN_COUNT  = 5'd5;

  // writable registers
  localparam reg_idx_t REG_HOST_IN_DATA = 5'd0;
  localparam reg_idx_t REG_HTIF_IN_DATA = 5'd1;
  localparam reg_idx_t REG_CHIP_RESET   = 5'd31;

  localparam int DEFAULT_FIFO_DEPTH = 32;  // power of two, 2 or more

endpackage

// ==== source/link_fifo.sv ====
`timescale 1ns/1ps

module link_fifo #(
  parameter int  FIFO_DEPTH = 32,
  parameter type payload_t  = logic [31:0]
) (
  input  logic                        host_clk,
  input  logic                        reset,
  input  logic                        push,
  input  payload_t                    push_data,
  input  logic                        pop,
  output payload_t                    head,
  output logic                        empty,
  output logic                        full,
  output logic [$clog2(FIFO_DEPTH):0] count
);

  localparam int ADDR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W  = ADDR_W + 1;

  payload_t          mem [FIFO_DEPTH];
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] rd_ptr;
  logic [CNT_W-1:0]  count_next;
  logic              do_push;
  logic              do_pop;

  assign do_pop  = pop && !empty;
  assign do_push = push && (!full || pop);  // a pop frees the slot when full

  // show-ahead, head valid whenever not empty
  assign head = mem[rd_ptr];

  always_comb
  begin
    count_next = count;
    if (do_push && !do_pop)
      count_next = count + 1'b1;
    else if (do_pop && !do_push)
      count_next = count - 1'b1;
  end

  always_ff @(posedge host_clk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge host_clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      empty  <= 1'b1;
      full   <= 1'b0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count_next;
      // flags follow the next count so they line up with it
      empty <= (count_next == '0);
      full  <= (count_next == CNT_W'(FIFO_DEPTH));
    end
  end

endmodule

// ==== source/host_reg_ctrl.sv ====
`timescale 1ns/1ps

module host_reg_ctrl #(
  parameter int FIFO_DEPTH = 32
) (
  input  logic                            host_clk,
  input  logic                            reset,
  input  host_bridge_pkg::axil_req_t      s_axil,
  output host_bridge_pkg::axil_rsp_t      s_axil_rsp,
  output logic                            host_in_push,
  output logic                            htif_in_push,
  output host_bridge_pkg::host_word_t     in_word,
  input  logic                            host_in_full,
  input  logic                            htif_in_full,
  input  logic [$clog2(FIFO_DEPTH):0]     host_in_count,
  input  logic [$clog2(FIFO_DEPTH):0]     htif_in_count,
  output logic                            host_out_pop,
  output logic                            htif_out_pop,
  input  host_bridge_pkg::host_word_t     host_out_head,
  input  host_bridge_pkg::htif_word_t     htif_out_head,
  input  logic                            host_out_empty,
  input  logic                            htif_out_empty,
  input  logic [$clog2(FIFO_DEPTH):0]     host_out_count,
  input  logic [$clog2(FIFO_DEPTH):0]     htif_out_count,
  output logic                            chip_reset
);

  import host_bridge_pkg::*;

  typedef enum logic [1:0] {WR_IDLE, WR_WRITE, WR_ACK} wr_state_t;
  typedef enum logic {RD_IDLE, RD_RESP} rd_state_t;

  wr_state_t   wr_state;
  rd_state_t   rd_state;
  reg_idx_t    waddr_q;
  host_word_t  wdata_q;
  logic [1:0]  bresp_q;
  logic        wr_ok;          // target can take the word now
  logic [1:0]  wr_resp;
  logic        wr_fire;
  reg_idx_t    raddr_q;
  logic [31:0] rdata_q;
  logic [1:0]  rresp_q;
  logic        rd_pop_ok_q;    // queue had a word at capture
  logic [31:0] rd_data;
  logic [1:0]  rd_resp;
  logic        rd_pop_ok;
  logic        ar_fire;
  logic        r_fire;

  // write side decode on the captured index
  always_comb
  begin
    wr_ok   = 1'b1;
    wr_resp = RESP_OKAY;
    case (waddr_q)
      REG_HOST_IN_DATA: wr_ok = !host_in_full;
      REG_HTIF_IN_DATA: wr_ok = !htif_in_full;
      REG_CHIP_RESET:   wr_ok = 1'b1;
      default:          wr_resp = RESP_SLVERR;  // unmapped, completes at once
    endcase
  end

  assign wr_fire = (wr_state == WR_WRITE) && wr_ok && s_axil.aw_valid && s_axil.w_valid;

  assign in_word      = wdata_q;
  assign host_in_push = wr_fire && (waddr_q == REG_HOST_IN_DATA);
  assign htif_in_push = wr_fire && (waddr_q == REG_HTIF_IN_DATA);
  assign chip_reset   = wr_fire && (waddr_q == REG_CHIP_RESET);  // one cycle wide

  always_ff @(posedge host_clk)
  begin
    if (reset)
      wr_state <= WR_IDLE;
    else
    begin
      case (wr_state)
        WR_IDLE:
        begin
          if (s_axil.aw_valid && s_axil.w_valid)
          begin
            waddr_q  <= s_axil.aw_addr[6:2];
            wdata_q  <= s_axil.w_data;  // strobes ignored
            wr_state <= WR_WRITE;
          end
        end
        WR_WRITE:
        begin
          if (wr_fire)
          begin
            bresp_q  <= wr_resp;
            wr_state <= WR_ACK;
          end
        end
        default:
        begin
          if (s_axil.b_ready)
            wr_state <= WR_IDLE;
        end
      endcase
    end
  end

  // read data picked from the incoming address
  always_comb
  begin
    rd_data   = '0;
    rd_resp   = RESP_OKAY;
    rd_pop_ok = 1'b0;
    case (s_axil.ar_addr[6:2])
      REG_HOST_OUT_COUNT: rd_data = 32'(host_out_count);
      REG_HTIF_OUT_COUNT: rd_data = 32'(htif_out_count);
      REG_HOST_IN_COUNT:  rd_data = 32'(host_in_count);
      REG_HTIF_IN_COUNT:  rd_data = 32'(htif_in_count);
      REG_HOST_OUT_DATA:
      begin
        rd_pop_ok = !host_out_empty;
        if (!host_out_empty)
          rd_data = host_out_head;
      end
      REG_HTIF_OUT_DATA:
      begin
        rd_pop_ok = !htif_out_empty;
        if (!htif_out_empty)
          rd_data = 32'(htif_out_head);
      end
      default: rd_resp = RESP_SLVERR;
    endcase
  end

  assign ar_fire = (rd_state == RD_IDLE) && s_axil.ar_valid;
  assign r_fire  = (rd_state == RD_RESP) && s_axil.r_ready;

  // pop only after the master has taken the word
  assign host_out_pop = r_fire && rd_pop_ok_q && (raddr_q == REG_HOST_OUT_DATA);
  assign htif_out_pop = r_fire && rd_pop_ok_q && (raddr_q == REG_HTIF_OUT_DATA);

  always_ff @(posedge host_clk)
  begin
    if (reset)
      rd_state <= RD_IDLE;
    else if (ar_fire)
    begin
      raddr_q     <= s_axil.ar_addr[6:2];
      rdata_q     <= rd_data;
      rresp_q     <= rd_resp;
      rd_pop_ok_q <= rd_pop_ok;
      rd_state    <= RD_RESP;
    end
    else if (r_fire)
      rd_state <= RD_IDLE;
  end

  always_comb
  begin
    s_axil_rsp          = '0;
    s_axil_rsp.aw_ready = (wr_state == WR_WRITE) && wr_ok;
    s_axil_rsp.w_ready  = (wr_state == WR_WRITE) && wr_ok;
    s_axil_rsp.b_valid  = (wr_state == WR_ACK);
    s_axil_rsp.b_resp   = bresp_q;
    s_axil_rsp.ar_ready = (rd_state == RD_IDLE);
    s_axil_rsp.r_valid  = (rd_state == RD_RESP);
    s_axil_rsp.r_data   = rdata_q;
    s_axil_rsp.r_resp   = rresp_q;
  end

endmodule

// ==== source/host_bridge_top.sv ====
`timescale 1ns/1ps

module host_bridge_top #(
  parameter int FIFO_DEPTH = host_bridge_pkg::DEFAULT_FIFO_DEPTH
) (
  input  logic                        host_clk,
  input  logic                        reset,
  input  host_bridge_pkg::axil_req_t  s_axil,
  output host_bridge_pkg::axil_rsp_t  s_axil_rsp,
  output logic                        host_in_valid,
  input  logic                        host_in_ready,
  output host_bridge_pkg::host_word_t host_in_bits,
  output logic                        htif_in_valid,
  input  logic                        htif_in_ready,
  output host_bridge_pkg::htif_word_t htif_in_bits,
  input  logic                        host_out_valid,
  output logic                        host_out_ready,
  input  host_bridge_pkg::host_word_t host_out_bits,
  input  logic                        htif_out_valid,
  output logic                        htif_out_ready,
  input  host_bridge_pkg::htif_word_t htif_out_bits,
  output logic                        chip_reset
);

  import host_bridge_pkg::*;

  localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

  host_word_t       in_word;
  htif_word_t       htif_in_word;
  logic             host_in_push, htif_in_push;
  logic             host_in_full, htif_in_full;
  logic             host_in_empty, htif_in_empty;
  logic [CNT_W-1:0] host_in_count, htif_in_count;
  logic             host_out_pop, htif_out_pop;
  logic             host_out_full, htif_out_full;
  logic             host_out_empty, htif_out_empty;
  logic [CNT_W-1:0] host_out_count, htif_out_count;
  host_word_t       host_out_head;
  htif_word_t       htif_out_head;

  assign htif_in_word = in_word[15:0];  // htif carries the low half

  // target side handshakes
  assign host_in_valid  = !host_in_empty;
  assign htif_in_valid  = !htif_in_empty;
  assign host_out_ready = !host_out_full;
  assign htif_out_ready = !htif_out_full;

  host_reg_ctrl #(.FIFO_DEPTH(FIFO_DEPTH)) ctrl (
    .host_clk, .reset, .s_axil, .s_axil_rsp,
    .host_in_push, .htif_in_push, .in_word,
    .host_in_full, .htif_in_full, .host_in_count, .htif_in_count,
    .host_out_pop, .htif_out_pop, .host_out_head, .htif_out_head,
    .host_out_empty, .htif_out_empty, .host_out_count, .htif_out_count,
    .chip_reset
  );

  link_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(host_word_t)) host_in_q (
    .host_clk, .reset, .push(host_in_push), .push_data(in_word),
    .pop(host_in_valid && host_in_ready), .head(host_in_bits),
    .empty(host_in_empty), .full(host_in_full), .count(host_in_count)
  );

  link_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(htif_word_t)) htif_in_q (
    .host_clk, .reset, .push(htif_in_push), .push_data(htif_in_word),
    .pop(htif_in_valid && htif_in_ready), .head(htif_in_bits),
    .empty(htif_in_empty), .full(htif_in_full), .count(htif_in_count)
  );

  link_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(host_word_t)) host_out_q (
    .host_clk, .reset, .push(host_out_valid && host_out_ready), .push_data(host_out_bits),
    .pop(host_out_pop), .head(host_out_head),
    .empty(host_out_empty), .full(host_out_full), .count(host_out_count)
  );

  link_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(htif_word_t)) htif_out_q (
    .host_clk, .reset, .push(htif_out_valid && htif_out_ready), .push_data(htif_out_bits),
    .pop(htif_out_pop), .head(htif_out_head),
    .empty(htif_out_empty), .full(htif_out_full), .count(htif_out_count)
  );

endmodule

// ==== tests/host_bridge_chk.sv ====
`timescale 1ns/1ps

module host_bridge_chk #(
  parameter int FIFO_DEPTH = 32
) (
  input logic                        host_clk,
  input logic                        reset,
  input host_bridge_pkg::axil_req_t  s_axil,
  input host_bridge_pkg::axil_rsp_t  s_axil_rsp,
  input logic                        host_in_push,
  input logic                        htif_in_push,
  input logic                        host_out_pop,
  input logic                        htif_out_pop,
  input logic                        chip_reset,
  input logic [$clog2(FIFO_DEPTH):0] host_in_count,
  input logic [$clog2(FIFO_DEPTH):0] htif_in_count
);

  // a completed write does one push or pulse, then sits in the response state
  one_write_action: assert property (@(posedge host_clk) disable iff (reset)
    (host_in_push || htif_in_push || chip_reset) |=>
      s_axil_rsp.b_valid && !(host_in_push || htif_in_push || chip_reset))
    else $error("more than one push or reset pulse in one write");

  one_read_action: assert property (@(posedge host_clk) disable iff (reset)
    (host_out_pop || htif_out_pop) |=> !(host_out_pop || htif_out_pop))
    else $error("more than one pop in one read");

  bvalid_after_write: assert property (@(posedge host_clk) disable iff (reset)
    $rose(s_axil_rsp.b_valid) |-> $past(s_axil.aw_valid && s_axil_rsp.aw_ready &&
                                        s_axil.w_valid && s_axil_rsp.w_ready))
    else $error("b_valid rose without a completed write");

  rvalid_held: assert property (@(posedge host_clk) disable iff (reset)
    s_axil_rsp.r_valid && !s_axil.r_ready |=> s_axil_rsp.r_valid && $stable(s_axil_rsp.r_data))
    else $error("r_valid or r_data changed before r_ready");

  // checked against the queue count, not the full flag the decode uses
  no_push_full: assert property (@(posedge host_clk) disable iff (reset)
    (host_in_push |-> host_in_count < FIFO_DEPTH) and
    (htif_in_push |-> htif_in_count < FIFO_DEPTH))
    else $error("push into a full inbound queue");

endmodule

bind host_reg_ctrl host_bridge_chk #(.FIFO_DEPTH(FIFO_DEPTH)) chk (
  .host_clk(host_clk), .reset(reset), .s_axil(s_axil), .s_axil_rsp(s_axil_rsp),
  .host_in_push(host_in_push), .htif_in_push(htif_in_push),
  .host_out_pop(host_out_pop), .htif_out_pop(htif_out_pop), .chip_reset(chip_reset),
  .host_in_count(host_in_count), .htif_in_count(htif_in_count)
);

// ==== tests/axil_tasks.svh ====
`ifndef AXIL_TASKS_SVH
`define AXIL_TASKS_SVH

localparam int WAIT_LIMIT = 200;  // cycles allowed per wait

function automatic logic [6:0] addr_of(input reg_idx_t idx);
  return {idx, 2'b00};
endfunction

// raise aw and w together, held until the slave takes them
task automatic start_write(input logic [6:0] addr, input logic [31:0] data);
  @(posedge host_clk);
  #1;
  s_axil.aw_valid = 1'b1;
  s_axil.aw_addr  = addr;
  s_axil.w_valid  = 1'b1;
  s_axil.w_data   = data;
  s_axil.w_strb   = 4'($urandom);  // ignored by the slave
endtask

task automatic finish_write(output logic [1:0] resp);
  int n;
  resp = 2'bxx;
  n    = 0;
  @(negedge host_clk);
  while (!(s_axil_rsp.aw_ready && s_axil_rsp.w_ready) && n < WAIT_LIMIT)
  begin
    @(negedge host_clk);
    n++;
  end
  @(posedge host_clk);  // aw and w handshake on this edge
  #1;
  s_axil.aw_valid = 1'b0;
  s_axil.w_valid  = 1'b0;
  if (n == WAIT_LIMIT)
  begin
    other_errs++;
    $display("timeout: write address and data were never accepted");
    return;
  end
  s_axil.b_ready = 1'b1;
  n = 0;
  @(negedge host_clk);
  while (!s_axil_rsp.b_valid && n < WAIT_LIMIT)
  begin
    @(negedge host_clk);
    n++;
  end
  if (n == WAIT_LIMIT)
  begin
    other_errs++;
    $display("timeout: no write response after the write was accepted");
  end
  resp = s_axil_rsp.b_resp;
  @(posedge host_clk);
  #1;
  s_axil.b_ready = 1'b0;
endtask

task automatic write_reg(input logic [6:0] addr, input logic [31:0] data,
                         output logic [1:0] resp);
  start_write(addr, data);
  finish_write(resp);
endtask

task automatic read_reg(input logic [6:0] addr, output logic [31:0] data,
                        output logic [1:0] resp);
  int n;
  int stall;
  @(posedge host_clk);
  #1;
  s_axil.ar_valid = 1'b1;
  s_axil.ar_addr  = addr;
  n = 0;
  @(negedge host_clk);
  while (!s_axil_rsp.ar_ready && n < WAIT_LIMIT)
  begin
    @(negedge host_clk);
    n++;
  end
  @(posedge host_clk);
  #1;
  s_axil.ar_valid = 1'b0;
  stall = int'($urandom_range(0, 2));  // master sometimes holds r_ready low
  repeat (stall)
  begin
    @(posedge host_clk);
    #1;
  end
  s_axil.r_ready  = 1'b1;
  @(negedge host_clk);
  while (!s_axil_rsp.r_valid && n < WAIT_LIMIT)
  begin
    @(negedge host_clk);
    n++;
  end
  if (n == WAIT_LIMIT)
  begin
    other_errs++;
    $display("timeout: read at address %h got no response", addr);
  end
  data = s_axil_rsp.r_data;
  resp = s_axil_rsp.r_resp;
  @(posedge host_clk);  // r handshake
  #1;
  s_axil.r_ready = 1'b0;
endtask

`endif

// ==== tests/host_bridge_tb.sv ====
`timescale 1ns/1ps

module host_bridge_tb;

  import host_bridge_pkg::*;

  logic       host_clk;
  logic       reset;
  axil_req_t  s_axil;
  axil_rsp_t  s_axil_rsp;
  logic       host_in_valid;
  logic       host_in_ready;
  host_word_t host_in_bits;
  logic       htif_in_valid;
  logic       htif_in_ready;
  htif_word_t htif_in_bits;
  logic       host_out_valid;
  logic       host_out_ready;
  host_word_t host_out_bits;
  logic       htif_out_valid;
  logic       htif_out_ready;
  htif_word_t htif_out_bits;
  logic       chip_reset;

  // reference queues, one per hardware queue
  host_word_t host_in_m[$:31];
  htif_word_t htif_in_m[$:31];
  host_word_t host_out_m[$:31];
  htif_word_t htif_out_m[$:31];

  int   value_errs;
  int   other_errs;
  int   reset_pulses;
  logic sink_rand;   // random ready on the inbound sinks
  logic sink_level;  // ready level when not random
  bit   report_done;

  `include "axil_tasks.svh"

  host_bridge_top #(.FIFO_DEPTH(DEFAULT_FIFO_DEPTH)) dut (.*);

  initial host_clk = 1'b0;
  always #5 host_clk = ~host_clk;

  task automatic expect_word(input string test, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else
    begin
      value_errs++;
      $display("** Error %s: expected %h, actual %h", test, exp, act);
    end
  endtask

  task automatic expect_resp(input string test, input logic [1:0] exp, input logic [1:0] act);
    assert (act === exp)
    else
    begin
      value_errs++;
      $display("** Error %s response: expected %b, actual %b", test, exp, act);
    end
  endtask

  always @(posedge host_clk)
  begin
    #1;
    host_in_ready = sink_rand ? 1'($urandom_range(0, 1)) : sink_level;
    htif_in_ready = sink_rand ? 1'($urandom_range(0, 1)) : sink_level;
  end

  // bus side model, a completed data write enters its model queue
  always @(negedge host_clk)
  begin
    if (!reset && s_axil.aw_valid && s_axil_rsp.aw_ready && s_axil.w_valid && s_axil_rsp.w_ready)
    begin
      if (s_axil.aw_addr[6:2] == REG_HOST_IN_DATA)
      begin
        assert (host_in_m.size() < 32)
        else
        begin
          other_errs++;
          $display("host_in write accepted while the queue was full");
        end
        host_in_m.push_back(s_axil.w_data);
      end
      else if (s_axil.aw_addr[6:2] == REG_HTIF_IN_DATA)
      begin
        assert (htif_in_m.size() < 32)
        else
        begin
          other_errs++;
          $display("htif_in write accepted while the queue was full");
        end
        htif_in_m.push_back(s_axil.w_data[15:0]);  // low half only
      end
    end
  end

  // inbound sinks, word moves on the next edge
  always @(negedge host_clk)
  begin
    if (!reset && host_in_valid && host_in_ready)
    begin
      assert (host_in_m.size() > 0)
      else
      begin
        other_errs++;
        $display("host_in delivered a word that was never written");
      end
      if (host_in_m.size() > 0)
        expect_word("inbound host_in", host_in_m.pop_front(), host_in_bits);
    end
    if (!reset && htif_in_valid && htif_in_ready)
    begin
      assert (htif_in_m.size() > 0)
      else
      begin
        other_errs++;
        $display("htif_in delivered a word that was never written");
      end
      if (htif_in_m.size() > 0)
        expect_word("inbound htif_in", 32'(htif_in_m.pop_front()), 32'(htif_in_bits));
    end
    if (!reset && chip_reset)
      reset_pulses++;
  end

  task automatic set_sink(input logic rand_mode, input logic level);
    @(negedge host_clk);
    sink_rand  = rand_mode;
    sink_level = level;
  endtask

  task automatic send_host_out(input int n);
    int         k;
    host_word_t w;
    repeat (n)
    begin
      w = $urandom;
      repeat (int'($urandom_range(1, 3))) @(posedge host_clk);  // random idle gap
      #1;
      host_out_valid = 1'b1;
      host_out_bits  = w;
      k = 0;
      @(negedge host_clk);
      while (!host_out_ready && k < WAIT_LIMIT)
      begin
        @(negedge host_clk);
        k++;
      end
      assert (k < WAIT_LIMIT)
      else
      begin
        other_errs++;
        $display("timeout: host_out never became ready");
      end
      if (k < WAIT_LIMIT)
        host_out_m.push_back(w);
      @(posedge host_clk);
      #1;
      host_out_valid = 1'b0;
    end
  endtask

  task automatic send_htif_out(input int n);
    int         k;
    htif_word_t w;
    repeat (n)
    begin
      w = 16'($urandom);
      repeat (int'($urandom_range(1, 3))) @(posedge host_clk);
      #1;
      htif_out_valid = 1'b1;
      htif_out_bits  = w;
      k = 0;
      @(negedge host_clk);
      while (!htif_out_ready && k < WAIT_LIMIT)
      begin
        @(negedge host_clk);
        k++;
      end
      assert (k < WAIT_LIMIT)
      else
      begin
        other_errs++;
        $display("timeout: htif_out never became ready");
      end
      if (k < WAIT_LIMIT)
        htif_out_m.push_back(w);
      @(posedge host_clk);
      #1;
      htif_out_valid = 1'b0;
    end
  endtask

  task automatic read_out(input string test, input bit from_htif);
    logic [31:0] d;
    logic [1:0]  r;
    logic [31:0] exp;
    exp = '0;  // empty queue reads as zero
    if (!from_htif && host_out_m.size() > 0)
      exp = host_out_m.pop_front();
    else if (from_htif && htif_out_m.size() > 0)
      exp = 32'(htif_out_m.pop_front());
    read_reg(addr_of(from_htif ? REG_HTIF_OUT_DATA : REG_HOST_OUT_DATA), d, r);
    expect_resp(test, RESP_OKAY, r);
    expect_word(test, exp, d);
  endtask

  task automatic write_in(input string test, input bit to_htif);
    logic [1:0] r;
    write_reg(addr_of(to_htif ? REG_HTIF_IN_DATA : REG_HOST_IN_DATA), $urandom, r);
    expect_resp(test, RESP_OKAY, r);
  endtask

  task automatic check_counts(input string test);
    logic [31:0] d;
    logic [1:0]  r;
    read_reg(addr_of(REG_HOST_IN_COUNT), d, r);
    expect_word({test, " host_in_count"}, 32'(host_in_m.size()), d);
    read_reg(addr_of(REG_HTIF_IN_COUNT), d, r);
    expect_word({test, " htif_in_count"}, 32'(htif_in_m.size()), d);
    read_reg(addr_of(REG_HOST_OUT_COUNT), d, r);
    expect_word({test, " host_out_count"}, 32'(host_out_m.size()), d);
    read_reg(addr_of(REG_HTIF_OUT_COUNT), d, r);
    expect_word({test, " htif_out_count"}, 32'(htif_out_m.size()), d);
  endtask

  task automatic wait_drain(input string test);
    int n;
    n = 0;
    while ((host_in_m.size() != 0 || htif_in_m.size() != 0) && n < 1000)
    begin
      @(negedge host_clk);
      n++;
    end
    assert (n < 1000)
    else
    begin
      other_errs++;
      $display("timeout in %s: inbound queues did not drain", test);
    end
    @(posedge host_clk);
    #1;
  endtask

  initial
  begin
    logic [31:0] d;
    logic [1:0]  r;
    int          n;
    int          pulses_before;
    reg_idx_t    idx;
    void'($urandom(86007));
    s_axil         = '0;
    host_in_ready  = 1'b0;
    htif_in_ready  = 1'b0;
    host_out_valid = 1'b0;
    host_out_bits  = '0;
    htif_out_valid = 1'b0;
    htif_out_bits  = '0;
    sink_rand      = 1'b0;
    sink_level     = 1'b0;
    value_errs     = 0;
    other_errs     = 0;
    reset_pulses   = 0;
    reset          = 1'b1;
    repeat (2) @(posedge host_clk);
    #1;
    reset = 1'b0;

    // inbound order with random sink ready
    set_sink(1'b1, 1'b0);
    n = int'($urandom_range(20, 40));
    repeat (n) write_in("inbound_order", 1'($urandom_range(0, 1)));
    wait_drain("inbound_order");

    // outbound order, one extra read per queue hits empty
    n = int'($urandom_range(8, 24));
    fork
      send_host_out(n);
      send_htif_out(n);
    join
    repeat (n + 1) read_out("outbound_order host", 1'b0);
    repeat (n + 1) read_out("outbound_order htif", 1'b1);

    // counts with the sinks stalled
    set_sink(1'b0, 1'b0);
    fork
      send_host_out(10);
      send_htif_out(10);
    join
    check_counts("counts");
    repeat (24)
    begin
      case ($urandom_range(0, 3))
        0: write_in("counts", 1'b0);
        1: write_in("counts", 1'b1);
        2: read_out("counts host_out", 1'b0);
        default: read_out("counts htif_out", 1'b1);
      endcase
      check_counts("counts");
    end
    set_sink(1'b0, 1'b1);
    wait_drain("counts");

    // back-pressure, 33rd write waits for room
    set_sink(1'b0, 1'b0);
    repeat (32) write_in("back_pressure", 1'b0);
    start_write(addr_of(REG_HOST_IN_DATA), $urandom);
    n = 0;
    repeat (50)
    begin
      @(negedge host_clk);
      if (s_axil_rsp.b_valid || s_axil_rsp.aw_ready)
        n++;
    end
    assert (n == 0)
    else
    begin
      other_errs++;
      $display("back_pressure: a write to the full queue was accepted");
    end
    set_sink(1'b0, 1'b1);
    finish_write(r);
    expect_resp("back_pressure", RESP_OKAY, r);
    wait_drain("back_pressure");

    // chip reset pulse, then unmapped accesses
    set_sink(1'b0, 1'b0);
    pulses_before = reset_pulses;
    write_reg(addr_of(REG_CHIP_RESET), $urandom, r);
    expect_resp("chip_reset", RESP_OKAY, r);
    expect_word("chip_reset pulses", 32'(pulses_before + 1), 32'(reset_pulses));
    repeat (8)
    begin
      idx = reg_idx_t'($urandom_range(2, 30));
      write_reg(addr_of(idx), $urandom, r);
      expect_resp("unmapped_write", RESP_SLVERR, r);
      idx = reg_idx_t'($urandom_range(6, 31));
      read_reg(addr_of(idx), d, r);
      expect_resp("unmapped_read", RESP_SLVERR, r);
      expect_word("unmapped_read data", '0, d);
    end
    check_counts("unmapped");
    expect_word("unmapped pulses", 32'(pulses_before + 1), 32'(reset_pulses));

    $display("errors: value %0d, other %0d", value_errs, other_errs);
    report_done = 1'b1;
    if (value_errs == 0 && other_errs == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  final
  begin
    if (!report_done)
      $display("TESTBENCH FAILED");
  end

endmodule

// ==== vlog.f ====
+incdir+tests
source/host_bridge_pkg.sv
source/link_fifo.sv
source/host_reg_ctrl.sv
source/host_bridge_top.sv
tests/host_bridge_chk.sv
tests/host_bridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the host bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --timing -f vlog.f --top-module host_bridge_tb \
  -o host_bridge_sim \
  && ./obj_dir/host_bridge_sim > sim.log 2>&1
grep -q "TESTBENCH PASSED" sim.log 2>/dev/null \
  && echo "run_sim: simulation passed" \
  || { echo "run_sim: simulation failed, see sim.log"; exit 1; }
